/* files.f */
hdl/aib_pkg.sv
hdl/aib_redun_tx_steer.sv
hdl/aib_redun_rx_steer.sv
hdl/aib_io_chan.sv
hdl/aib_aux_chan.sv
hdl/aib_phy_mc.sv
dv/tb_clk_gen.sv
dv/aib_phy_mc_tb.sv

/* Bender.yml */
package:
  name: aib_phy_mc

sources:
  - hdl/aib_pkg.sv
  - hdl/aib_redun_tx_steer.sv
  - hdl/aib_redun_rx_steer.sv
  - hdl/aib_io_chan.sv
  - hdl/aib_aux_chan.sv
  - hdl/aib_phy_mc.sv

  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/aib_phy_mc_tb.sv

/* dv/aib_phy_mc_tb.sv */
`default_nettype none

module aib_phy_mc_tb;

  localparam int NCH     = 2;
  localparam int NDAT    = 16;
  localparam int NPAIR   = NDAT/2 + aib_pkg::SPARE_PAIRS;
  localparam int NBMP    = 2*NPAIR;
  localparam int CSW     = $clog2(NCH);
  localparam int SELW    = CSW + 1;
  localparam int DRV_DLY = 10;   // Drive point after rising edge
  localparam int TMO     = 50;   // Cycle budget of any wait loop

  logic                          clk;
  logic                          reset;
  logic [NCH-1:0][NDAT-1:0]      tx_data;
  logic [NCH-1:0][NBMP-1:0]      bump_tx;
  logic [NCH-1:0][NBMP-1:0]      bump_rx;
  logic [NCH-1:0][NDAT-1:0]      rx_data;
  logic [NCH-1:0][NPAIR-1:0]     redun_engage;
  logic [NCH-1:0]                adap_rstn_in;
  logic [NCH-1:0]                adap_rstn_out;
  aib_pkg::aux_ctrl_t            aux_ctrl;
  logic [aib_pkg::AUX_BUMPS-1:0] aux_bump_tx;
  logic [aib_pkg::AUX_BUMPS-1:0] aux_bump_rx;
  aib_pkg::aux_stat_t            aux_stat;
  logic [SELW-1:0]               dig_test_sel;
  aib_pkg::phy_dbg_u             dig_test_bus;
  logic [CSW-1:0]                sel_ch;

  logic [NCH-1:0]      corrupt_en;     // Partner garbles one pair
  logic [NCH-1:0][3:0] corrupt_pair;
  logic [NCH-1:0][1:0] garbage;
  logic [NCH-1:0][3:0] idle_pair;      // Physical pair expected quiet
  logic [NCH-1:0][3:0] dbg_fp;         // Expected fault_pair field
  logic [NCH-1:0]      dbg_active;
  logic [NCH-1:0]      loop_chk;       // Check enables, one per test
  logic [NCH-1:0]      arst_chk;
  logic                master_chk;
  logic                slave_chk;
  logic                dbg_chk;
  logic [31:0]         lfsr_state;
  int                  errors;
  int                  tests_run;
  int                  tests_failed;
  int                  errs_before;

  tb_clk_gen clk_gen_i (.clk(clk), .reset(reset));

  aib_phy_mc #(.NCH(NCH), .NDAT(NDAT)) aib_phy_mc_i (
    .tx_clk        (clk),
    .reset         (reset),
    .tx_data       (tx_data),
    .bump_tx       (bump_tx),
    .bump_rx       (bump_rx),
    .rx_data       (rx_data),
    .redun_engage  (redun_engage),
    .adap_rstn_in  (adap_rstn_in),
    .adap_rstn_out (adap_rstn_out),
    .aux_ctrl      (aux_ctrl),
    .aux_bump_tx   (aux_bump_tx),
    .aux_bump_rx   (aux_bump_rx),
    .aux_stat      (aux_stat),
    .dig_test_sel  (dig_test_sel),
    .dig_test_bus  (dig_test_bus)
  );

  // Partner die, bumps wired straight back except the garbled pair
  always_comb begin
    bump_rx = bump_tx;
    for (int c = 0; c < NCH; c++) begin
      if (corrupt_en[c]) bump_rx[c][2*corrupt_pair[c] +: 2] = garbage[c];
    end
  end

  assign sel_ch = dig_test_sel[CSW-1:0];

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  for (genvar c = 0; c < NCH; c++) begin : g_chk
    // Two registers between tx_data and rx_data through the partner
    loop_a: assert property (@(posedge clk) disable iff (reset || !loop_chk[c])
      rx_data[c] == $past(tx_data[c], 2))
      else report_mismatch($sformatf("ch %0d rx_data %h lost loopback", c, $sampled(rx_data[c])));
    idle_a: assert property (@(posedge clk) disable iff (reset || !loop_chk[c])
      bump_tx[c][2*idle_pair[c] +: 2] == 2'b00)
      else report_mismatch($sformatf("ch %0d idle pair %0d driven", c, idle_pair[c]));
    // Sync delay, then the data register clears one edge later
    arst_a: assert property (@(posedge clk) disable iff (reset || !arst_chk[c])
      $fell(adap_rstn_in[c]) |-> ##2 !adap_rstn_out[c] ##1 (rx_data[c] == '0))
      else report_mismatch($sformatf("ch %0d adapter reset not seen", c));
  end

  // AUX lane 0 is POR, lane 1 presence
  master_a: assert property (@(posedge clk) disable iff (reset || !master_chk)
    (aux_stat.por_out == ($past(aux_bump_rx[0], 2) && !aux_ctrl.por_ovrd)) &&
    !aux_stat.device_detect)
    else report_mismatch("master por_out wrong");
  slave_a: assert property (@(posedge clk) disable iff (reset || !slave_chk)
    (aux_stat.device_detect == ($past(aux_bump_rx[1], 2) || aux_ctrl.device_detect_ovrd)) &&
    !aux_stat.por_out)
    else report_mismatch("slave device_detect wrong");
  // Master marks presence only, slave sends its POR on lane 0
  aux_tx_a: assert property (@(posedge clk) disable iff (reset || !(master_chk || slave_chk))
    aux_bump_tx == (aux_ctrl.ms_nsl ? 2'b10 : {1'b0, aux_ctrl.por_in}))
    else report_mismatch($sformatf("aux_bump_tx %b", $sampled(aux_bump_tx)));

  dbg_io_a: assert property (@(posedge clk) disable iff (reset || !dbg_chk)
    dig_test_sel[CSW] |->
      (dig_test_bus.io.link_up == adap_rstn_in[sel_ch]) &&
      (dig_test_bus.io.redun_active == dbg_active[sel_ch]) &&
      (dig_test_bus.io.fault_pair == dbg_fp[sel_ch]) &&
      (dig_test_bus.io.rx_parity == ^rx_data[sel_ch]) &&
      (dig_test_bus.io.tx_parity == ^bump_tx[sel_ch]))
    else report_mismatch($sformatf("io debug byte %h", $sampled(dig_test_bus)));
  dbg_aux_a: assert property (@(posedge clk) disable iff (reset || !dbg_chk)
    !dig_test_sel[CSW] |->
      (dig_test_bus.aux.ms_nsl == aux_ctrl.ms_nsl) &&
      (dig_test_bus.aux.por_out == aux_stat.por_out) &&
      (dig_test_bus.aux.device_detect == aux_stat.device_detect))
    else report_mismatch($sformatf("aux debug byte %h", $sampled(dig_test_bus)));

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);   // One step per bit
    end
    return bits;
  endfunction

  // Random traffic on every free input, driven off the edge
  task automatic run_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #(DRV_DLY);
      for (int c = 0; c < NCH; c++) begin
        tx_data[c] = NDAT'(take_bits(NDAT));
        garbage[c] = 2'(take_bits(2));
      end
      aux_bump_rx                 = 2'(take_bits(2));
      aux_ctrl.por_in             = 1'(take_bits(1));
      aux_ctrl.por_ovrd           = 1'(take_bits(1));
      aux_ctrl.device_detect_ovrd = 1'(take_bits(1));
      dig_test_sel                = SELW'(take_bits(SELW));
    end
  endtask

  task automatic set_redundancy(input int c, input int f, input bit engaged);
    logic [NPAIR-1:0] upper;
    upper = NPAIR'(take_bits(NPAIR));
    if (engaged) begin
      // Stray bits above f must not move the fault
      redun_engage[c] = (upper & ~((NPAIR'(2) << f) - 1)) | (NPAIR'(1) << f);
      idle_pair[c]    = 4'(f);
      dbg_fp[c]       = 4'(f);
      dbg_active[c]   = 1'b1;
    end else begin
      redun_engage[c] = '0;
      idle_pair[c]    = 4'(NPAIR - 1);   // Spare pair idle
      dbg_fp[c]       = '0;
      dbg_active[c]   = 1'b0;
    end
  endtask

  task automatic wait_reset_release();
    int cnt;
    cnt = 0;
    while (reset !== 1'b0 && cnt < TMO) begin
      @(posedge clk);
      #(DRV_DLY);
      cnt++;
    end
    if (reset !== 1'b0) begin
      $display("timeout: reset never released");
      errors++;
    end
  endtask

  task automatic wait_links_up();
    int cnt;
    cnt = 0;
    while (adap_rstn_out != '1 && cnt < TMO) begin
      run_cycles(1);
      cnt++;
    end
    if (adap_rstn_out != '1) begin
      $display("timeout: adapter reset did not return on every channel");
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %-12s ok", name);
    end else begin
      $display("test %-12s %0d errors", name, errors - errs_before);
      tests_failed++;
    end
    errs_before = errors;
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    int f;
    lfsr_state   = 32'h3274;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    errs_before  = 0;
    tx_data      = '0;
    redun_engage = '0;
    adap_rstn_in = '0;
    aux_ctrl     = '0;
    aux_bump_rx  = '0;
    dig_test_sel = '0;
    corrupt_en   = '0;
    corrupt_pair = '0;
    garbage      = '0;
    loop_chk     = '0;
    arst_chk     = '0;
    master_chk   = 1'b0;
    slave_chk    = 1'b0;
    dbg_chk      = 1'b0;
    for (int c = 0; c < NCH; c++) set_redundancy(c, 0, 1'b0);

    wait_reset_release();
    adap_rstn_in = '1;
    wait_links_up();
    run_cycles(3);   // Pipeline fills

    loop_chk = '1;   // Plain loopback
    run_cycles(40);
    loop_chk = '0;
    report_test("loopback");

    for (int r = 0; r < 6; r++) begin
      for (int c = 0; c < NCH; c++) begin
        f = int'(take_bits(4)) % NPAIR;
        set_redundancy(c, f, 1'b1);
        corrupt_pair[c] = 4'(f);
      end
      corrupt_en = '1;
      run_cycles(3);   // Old steering drains
      loop_chk = '1;
      run_cycles(20);
      loop_chk = '0;
    end
    corrupt_en = '0;
    for (int c = 0; c < NCH; c++) set_redundancy(c, 0, 1'b0);
    run_cycles(3);
    report_test("redundancy");

    for (int ch = 0; ch < NCH; ch++) begin
      loop_chk         = '1;   // Other channel keeps looping
      loop_chk[ch]     = 1'b0;
      arst_chk[ch]     = 1'b1;
      adap_rstn_in[ch] = 1'b0;
      run_cycles(6);
      adap_rstn_in[ch] = 1'b1;
      wait_links_up();
      arst_chk[ch] = 1'b0;
      run_cycles(3);
    end
    loop_chk = '0;
    report_test("adap_reset");

    aux_ctrl.ms_nsl = 1'b1;
    master_chk      = 1'b1;
    run_cycles(30);
    master_chk      = 1'b0;
    aux_ctrl.ms_nsl = 1'b0;
    slave_chk       = 1'b1;
    run_cycles(30);
    slave_chk = 1'b0;
    report_test("aux_roles");

    dbg_chk = 1'b1;   // Debug fields are combinational, no settle
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < NCH; c++) begin
        f = int'(take_bits(4)) % NPAIR;
        set_redundancy(c, f, 1'(take_bits(1)));
      end
      aux_ctrl.ms_nsl = 1'(take_bits(1));
      run_cycles(12);
    end
    dbg_chk = 1'b0;
    report_test("debug_sel");

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 100,   // Clock period in time units
  parameter int RST_CYCLES = 5,     // Reset held for this many edges
  parameter int DRV_DLY    = 10     // Reset release point after the edge
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #(DRV_DLY) reset = 1'b0;   // Released off the edge like any input
  end

endmodule

`default_nettype wire

/* hdl/aib_phy_mc.sv */
`default_nettype none

module aib_phy_mc #(
  parameter  int NCH   = 2,    // IO channels
  parameter  int NDAT  = 16,   // Data lanes per channel, even, up to 30
  localparam int NPAIR = NDAT/2 + aib_pkg::SPARE_PAIRS,
  localparam int NBMP  = 2*NPAIR,
  localparam int CSW   = $clog2(NCH)   // Channel select bits
) (
  input  logic                               tx_clk,
  input  logic                               reset,
  // Data
  input  logic [NCH-1:0][NDAT-1:0]           tx_data,
  output logic [NCH-1:0][NBMP-1:0]           bump_tx,
  input  logic [NCH-1:0][NBMP-1:0]           bump_rx,
  output logic [NCH-1:0][NDAT-1:0]           rx_data,
  // Per channel control
  input  logic [NCH-1:0][NPAIR-1:0]          redun_engage,
  input  logic [NCH-1:0]                     adap_rstn_in,
  output logic [NCH-1:0]                     adap_rstn_out,
  // AUX
  input  aib_pkg::aux_ctrl_t                 aux_ctrl,
  output logic [aib_pkg::AUX_BUMPS-1:0]      aux_bump_tx,
  input  logic [aib_pkg::AUX_BUMPS-1:0]      aux_bump_rx,
  output aib_pkg::aux_stat_t                 aux_stat,
  // Debug
  input  logic [CSW:0]                       dig_test_sel,  // MSB set selects IO
  output aib_pkg::phy_dbg_u                  dig_test_bus
);

  aib_pkg::phy_dbg_u [NCH-1:0] io_dbg;
  aib_pkg::phy_dbg_u           aux_dbg;
  aib_pkg::phy_dbg_u           io_sel_dbg;   // Selected IO channel byte

  // Pair count must fit the fault index field
  if ((NDAT % 2) != 0 || NDAT > 30) begin : g_bad_ndat
    $error("aib_phy_mc: NDAT %0d must be even and at most 30", NDAT);
  end
  if ($bits(aib_pkg::phy_dbg_u) != aib_pkg::DBG_W) begin : g_bad_dbg
    $error("aib_phy_mc: debug byte is not %0d bits", aib_pkg::DBG_W);
  end

  // ---------------------------------------------------------
  // IO channels
  // ---------------------------------------------------------
  for (genvar c = 0; c < NCH; c++) begin : g_ch
    aib_io_chan #(.NDAT(NDAT)) io_chan_i (
      .tx_clk        (tx_clk),
      .reset         (reset),
      .adap_rstn_in  (adap_rstn_in[c]),
      .adap_rstn_out (adap_rstn_out[c]),
      .redun_engage  (redun_engage[c]),
      .tx_data       (tx_data[c]),
      .bump_tx       (bump_tx[c]),
      .bump_rx       (bump_rx[c]),
      .rx_data       (rx_data[c]),
      .dbg           (io_dbg[c])
    );
  end

  // ---------------------------------------------------------
  // AUX channel
  // ---------------------------------------------------------
  aib_aux_chan aux_chan_i (
    .tx_clk      (tx_clk),
    .reset       (reset),
    .aux_ctrl    (aux_ctrl),
    .aux_bump_tx (aux_bump_tx),
    .aux_bump_rx (aux_bump_rx),
    .aux_stat    (aux_stat),
    .dbg         (aux_dbg)
  );

  // ---------------------------------------------------------
  // Debug byte select
  // ---------------------------------------------------------
  if (NCH == 1) begin : g_one_ch
    assign io_sel_dbg = io_dbg[0];   // No channel index bits
  end else begin : g_multi_ch
    logic [CSW-1:0] ch_sel;
    assign ch_sel     = dig_test_sel[CSW-1:0];
    assign io_sel_dbg = (ch_sel < NCH) ? io_dbg[ch_sel] : io_dbg[0];  // Out of range to ch 0
  end

  assign dig_test_bus = dig_test_sel[CSW] ? io_sel_dbg : aux_dbg;

endmodule

`default_nettype wire

/* hdl/aib_aux_chan.sv */
`default_nettype none

module aib_aux_chan (
  input  logic                            tx_clk,
  input  logic                            reset,
  input  aib_pkg::aux_ctrl_t              aux_ctrl,
  output logic [aib_pkg::AUX_BUMPS-1:0]   aux_bump_tx,
  input  logic [aib_pkg::AUX_BUMPS-1:0]   aux_bump_rx,
  output aib_pkg::aux_stat_t              aux_stat,
  output aib_pkg::phy_dbg_u               dbg
);

  localparam int POR_LANE = 0;   // Slave to master POR
  localparam int DET_LANE = 1;   // Master presence for slave detect

  logic [aib_pkg::AUX_BUMPS-1:0] rx_meta;   // First sync stage
  logic [aib_pkg::AUX_BUMPS-1:0] rx_sync;   // Second sync stage
  aib_pkg::aux_dbg_t             aux_view;

  // ---------------------------------------------------------
  // Lanes driven to the partner
  // ---------------------------------------------------------
  always_comb begin
    aux_bump_tx           = '0;
    aux_bump_tx[POR_LANE] = !aux_ctrl.ms_nsl && aux_ctrl.por_in;  // Slave sends POR
    aux_bump_tx[DET_LANE] = aux_ctrl.ms_nsl;                      // Master presence
  end

  // ---------------------------------------------------------
  // Partner lane synchronizer
  // ---------------------------------------------------------
  always_ff @(posedge tx_clk) begin
    if (reset) begin
      rx_meta <= '0;
      rx_sync <= '0;
    end else begin
      rx_meta <= aux_bump_rx;
      rx_sync <= rx_meta;
    end
  end

  // Role select, then overrides
  always_comb begin
    aux_stat.por_out       = aux_ctrl.ms_nsl && rx_sync[POR_LANE] && !aux_ctrl.por_ovrd;
    aux_stat.device_detect = !aux_ctrl.ms_nsl &&
                             (rx_sync[DET_LANE] || aux_ctrl.device_detect_ovrd);
  end

  // ---------------------------------------------------------
  // Debug byte
  // ---------------------------------------------------------
  always_comb begin
    aux_view.ms_nsl        = aux_ctrl.ms_nsl;
    aux_view.por_out       = aux_stat.por_out;
    aux_view.device_detect = aux_stat.device_detect;
    aux_view.aux_rx        = rx_sync;
    aux_view.aux_tx        = aux_bump_tx;
    aux_view.rsvd          = 1'b0;
  end

  assign dbg.aux = aux_view;

  // A die is either master or slave, never reports both
  role_excl_a: assert property (
    @(posedge tx_clk) disable iff (reset)
    !(aux_stat.por_out && aux_stat.device_detect)
  ) else $error("aux chan: por_out and device_detect both high");

endmodule

`default_nettype wire

/* hdl/aib_io_chan.sv */
`default_nettype none

module aib_io_chan #(
  parameter  int NDAT  = 16,
  localparam int NPAIR = NDAT/2 + aib_pkg::SPARE_PAIRS,
  localparam int NBMP  = 2*NPAIR
) (
  input  logic              tx_clk,
  input  logic              reset,
  input  logic              adap_rstn_in,   // Adapter reset, active low
  output logic              adap_rstn_out,  // Synchronized loopback of it
  input  logic [NPAIR-1:0]  redun_engage,
  input  logic [NDAT-1:0]   tx_data,
  output logic [NBMP-1:0]   bump_tx,
  input  logic [NBMP-1:0]   bump_rx,
  output logic [NDAT-1:0]   rx_data,
  output aib_pkg::phy_dbg_u dbg
);

  logic [1:0]                    rstn_sync;    // Two-flop adapter reset sync
  logic                          link_up;
  logic [NBMP-1:0]               tx_steered;
  logic [NDAT-1:0]               rx_steered;
  logic [aib_pkg::MAX_PAIRS-1:0] engage_ext;
  aib_pkg::io_dbg_t              io_view;

  // ---------------------------------------------------------
  // Adapter reset synchronizer
  // ---------------------------------------------------------
  always_ff @(posedge tx_clk) begin
    if (reset) begin
      rstn_sync <= '0;
    end else begin
      rstn_sync <= {rstn_sync[0], adap_rstn_in};
    end
  end

  assign link_up       = rstn_sync[1];
  assign adap_rstn_out = link_up;   // Looped back to reset controller

  // ---------------------------------------------------------
  // TX path
  // ---------------------------------------------------------
  aib_redun_tx_steer #(.NDAT(NDAT)) tx_steer_i (
    .redun_engage (redun_engage),
    .data         (tx_data),
    .bumps        (tx_steered)
  );

  always_ff @(posedge tx_clk) begin
    if (reset || !link_up) begin
      bump_tx <= '0;          // Lanes quiet until adapter out of reset
    end else begin
      bump_tx <= tx_steered;
    end
  end

  // ---------------------------------------------------------
  // RX path
  // ---------------------------------------------------------
  aib_redun_rx_steer #(.NDAT(NDAT)) rx_steer_i (
    .redun_engage (redun_engage),
    .bumps        (bump_rx),
    .data         (rx_steered)
  );

  always_ff @(posedge tx_clk) begin
    if (reset || !link_up) begin
      rx_data <= '0;
    end else begin
      rx_data <= rx_steered;
    end
  end

  // ---------------------------------------------------------
  // Debug byte
  // ---------------------------------------------------------
  always_comb begin
    engage_ext            = '0;
    engage_ext[NPAIR-1:0] = redun_engage;
  end

  always_comb begin
    io_view.link_up      = link_up;
    io_view.redun_active = |redun_engage;
    io_view.fault_pair   = aib_pkg::lowest_pair(engage_ext);   // 0 when idle
    io_view.rx_parity    = ^rx_data;
    io_view.tx_parity    = ^bump_tx;
  end

  assign dbg.io = io_view;

  // Adapter reset held through the sync leaves both data registers cleared
  link_down_clear_a: assert property (
    @(posedge tx_clk) disable iff (reset)
    (!adap_rstn_in) [*3] |=> (bump_tx == '0) && (rx_data == '0)
  ) else $error("io chan: data registers not cleared while link down");

endmodule

`default_nettype wire

/* hdl/aib_redun_rx_steer.sv */
`default_nettype none

// Undoes the TX pair shift, faulty and unused spare pairs never read
module aib_redun_rx_steer #(
  parameter  int NDAT  = 16,
  localparam int NPAIR = NDAT/2 + aib_pkg::SPARE_PAIRS,
  localparam int NBMP  = 2*NPAIR
) (
  input  logic [NPAIR-1:0] redun_engage,
  input  logic [NBMP-1:0]  bumps,
  output logic [NDAT-1:0]  data
);

  localparam int NLOG      = NDAT/2;     // Logical data pairs
  localparam int SPARE_IDX = NPAIR - 1;

  logic [aib_pkg::MAX_PAIRS-1:0] engage_ext;
  int unsigned                   fault;

  // ---------------------------------------------------------
  // Faulty pair decode, same rule as TX
  // ---------------------------------------------------------
  always_comb begin
    engage_ext            = '0;
    engage_ext[NPAIR-1:0] = redun_engage;
  end

  assign fault = (|redun_engage) ? int'(aib_pkg::lowest_pair(engage_ext)) : SPARE_IDX;

  // ---------------------------------------------------------
  // Inverse pair mux
  // ---------------------------------------------------------
  always_comb begin
    for (int l = 0; l < NLOG; l++) begin
      if (l < fault) begin
        data[2*l +: 2] = bumps[2*l +: 2];         // Below fault, straight
      end else begin
        data[2*l +: 2] = bumps[2*(l+1) +: 2];     // Skip over faulty pair
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/aib_redun_tx_steer.sv */
`default_nettype none

// Logical pairs at or above the faulty pair shift up one physical pair
module aib_redun_tx_steer #(
  parameter  int NDAT  = 16,
  localparam int NPAIR = NDAT/2 + aib_pkg::SPARE_PAIRS,
  localparam int NBMP  = 2*NPAIR
) (
  input  logic [NPAIR-1:0] redun_engage,  // One bit per physical pair
  input  logic [NDAT-1:0]  data,
  output logic [NBMP-1:0]  bumps
);

  localparam int SPARE_IDX = NPAIR - 1;   // Zeroed when nothing engaged

  logic [aib_pkg::MAX_PAIRS-1:0] engage_ext;
  logic [NBMP+1:0]               data_pad;  // Data with a zero pair on each side
  int unsigned                   fault;     // Physical pair left idle

  // ---------------------------------------------------------
  // Faulty pair decode
  // ---------------------------------------------------------
  always_comb begin
    engage_ext                = '0;
    engage_ext[NPAIR-1:0]     = redun_engage;
  end

  assign fault = (|redun_engage) ? int'(aib_pkg::lowest_pair(engage_ext)) : SPARE_IDX;

  // ---------------------------------------------------------
  // Pair mux
  // ---------------------------------------------------------
  assign data_pad = {2'b00, data, 2'b00};

  always_comb begin
    for (int p = 0; p < NPAIR; p++) begin
      if (p < fault) begin
        bumps[2*p +: 2] = data_pad[2*p + 2 +: 2];   // Same pair
      end else if (p == fault) begin
        bumps[2*p +: 2] = 2'b00;                    // Faulty pair idle
      end else begin
        bumps[2*p +: 2] = data_pad[2*p +: 2];       // Pair below, shifted up
      end
    end
  end

  // No data bit dropped, none copied onto the idle pair
  bit_count_a: assert #0 ($countones(bumps) == $countones(data))
    else $error("tx steer: %0d ones on bumps for %0d in data",
                $countones(bumps), $countones(data));

endmodule

`default_nettype wire

/* hdl/aib_pkg.sv */
`default_nettype none

package aib_pkg;

  // ---------------------------------------------------------
  // Channel geometry
  // ---------------------------------------------------------
  localparam int SPARE_PAIRS = 1;   // Spare lane pairs per IO channel
  localparam int AUX_BUMPS   = 2;   // Lane 0 POR, lane 1 presence
  localparam int DBG_W       = 8;   // Debug byte width

  localparam int FP_W      = 4;           // Fault pair index width
  localparam int MAX_PAIRS = 1 << FP_W;   // Pairs addressable by a fault index

  // ---------------------------------------------------------
  // AUX static controls and results
  // ---------------------------------------------------------
  typedef struct packed {
    logic ms_nsl;               // 1 = master, 0 = slave
    logic por_in;               // Slave POR from external controller
    logic por_ovrd;             // Forces master por_out low
    logic device_detect_ovrd;   // Forces slave device_detect high
  } aux_ctrl_t;

  typedef struct packed {
    logic por_out;        // Master only
    logic device_detect;  // Slave only
  } aux_stat_t;

  // ---------------------------------------------------------
  // Debug byte views
  // ---------------------------------------------------------
  typedef struct packed {
    logic            link_up;       // Synchronized adapter reset
    logic            redun_active;  // Any pair engaged
    logic [FP_W-1:0] fault_pair;    // Lowest engaged pair
    logic            rx_parity;
    logic            tx_parity;
  } io_dbg_t;

  typedef struct packed {
    logic       ms_nsl;
    logic       por_out;
    logic       device_detect;
    logic [1:0] aux_rx;   // Synchronized partner lanes
    logic [1:0] aux_tx;   // Lanes driven to partner
    logic       rsvd;     // Always zero
  } aux_dbg_t;

  // Same byte, meaning set by its source channel
  typedef union packed {
    io_dbg_t  io;
    aux_dbg_t aux;
  } phy_dbg_u;

  // Index of lowest set bit, 0 if none
  function automatic logic [FP_W-1:0] lowest_pair(input logic [MAX_PAIRS-1:0] engage);
    logic [FP_W-1:0] idx;
    idx = '0;
    for (int i = MAX_PAIRS - 1; i >= 0; i--) begin
      if (engage[i]) idx = FP_W'(i);   // Last hit is the lowest
    end
    return idx;
  endfunction

endpackage

`default_nettype wire
